// File: logic/dma_pkg.sv
/* Shared constants and payload types of the multi-channel read DMA front end.
   Imported by the interfaces and RTL blocks that use them */
package dma_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  localparam int N_CHAN        = 4;
  localparam int DATA_BITS     = 64;
  localparam int LEN_BITS      = 16;
  localparam int ADDR_BITS     = 32;
  // 8 bytes per beat
  localparam int BEAT_LOG_BITS = 3;
  localparam int BLEN_BITS     = LEN_BITS - BEAT_LOG_BITS;
  localparam int CHAN_BITS     = 2;
  // Depth of each sequence queue, bounds requests in flight
  localparam int N_OUTSTANDING = 8;

  // ----------------------------------------
  // Types
  // ----------------------------------------
  // Read request, 49 bits
  typedef struct packed {
    logic [ADDR_BITS-1:0] addr;
    logic [LEN_BITS-1:0]  len;
    logic                 ctl;
  } dma_req_t;

  // Completion back to the channel
  typedef struct packed {
    logic done;
  } dma_rsp_t;

  // Routing entry, n_tr holds beat count minus one
  typedef struct packed {
    logic                 last;
    logic [CHAN_BITS-1:0] chan;
    logic [BLEN_BITS-1:0] n_tr;
  } mux_seq_t;

endpackage

// File: logic/dma_req_if.sv
/* Request/response link between a user channel and the arbiter.
   snk is the arbiter's receiving side, src the side that issues commands */
`timescale 1ns/1ps

interface dma_req_if
  import dma_pkg::*;
();

  // Handshake
  logic     valid;
  logic     ready;

  // Payloads
  dma_req_t req;
  dma_rsp_t rsp;

  // Accepts requests, returns ready and done
  modport snk (
    input  valid, req,
    output ready, rsp
  );

  // Issues requests, receives ready and done
  modport src (
    output valid, req,
    input  ready, rsp
  );

endinterface

// File: logic/meta_if.sv
/* Generic valid/ready stream carrying one STYPE word per transfer */
`timescale 1ns/1ps

interface meta_if #(
  parameter type STYPE = logic
) ();

  logic valid;
  logic ready;
  STYPE data;

  // Producer side
  modport m (output valid, data, input ready);

  // Consumer side
  modport s (input valid, data, output ready);

endinterface

// File: logic/seq_queue.sv
/* Registered FIFO of N_OUTSTANDING entries, payload set by QTYPE.
   Holds the routing and completion sequences of granted requests */
`timescale 1ns/1ps

module seq_queue
  import dma_pkg::*;
#(
  parameter type QTYPE = logic
) (
  input  logic aclk,
  input  logic aresetn,
  input  logic val_snk,
  output logic rdy_snk,
  input  QTYPE data_snk,
  output logic val_src,
  input  logic rdy_src,
  output QTYPE data_src
);

  // Storage
  QTYPE mem [N_OUTSTANDING];

  logic [$clog2(N_OUTSTANDING)-1:0]   wr_ptr;
  logic [$clog2(N_OUTSTANDING)-1:0]   rd_ptr;
  logic [$clog2(N_OUTSTANDING+1)-1:0] count;
  logic push;
  logic pop;

  assign push = val_snk && rdy_snk;
  assign pop  = val_src && rdy_src;

  // Status flags
  assign rdy_snk  = (count != N_OUTSTANDING);
  assign val_src  = (count != 0);
  assign data_src = mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= data_snk;
    end
  end

  // Pointers and fill level
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == N_OUTSTANDING - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == N_OUTSTANDING - 1) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Producer only offers when space was granted
  a_no_push_full: assert property (@(posedge aclk) disable iff (!aresetn)
    (count == N_OUTSTANDING) |-> !val_snk);

  // Consumer only pops an existing entry
  a_no_pop_empty: assert property (@(posedge aclk) disable iff (!aresetn)
    (count == 0) |-> !rdy_src);

endmodule

// File: logic/dma_arbiter.sv
/* Round-robin arbiter from N_CHAN request links onto one command link.
   Every grant queues a routing entry for the data mux and a completion entry */
`timescale 1ns/1ps

module dma_arbiter
  import dma_pkg::*;
(
  input  logic aclk,
  input  logic aresetn,
  dma_req_if.snk req_snk [N_CHAN],
  dma_req_if.src req_src,
  meta_if.m      mux
);

  // Channel side, flattened
  logic [N_CHAN-1:0] valid_snk;
  dma_req_t          request_snk [N_CHAN];

  // Command side
  logic valid_src;
  logic ready_src;
  logic done_src;
  logic grant;

  // Selection
  logic [CHAN_BITS-1:0] rr_ptr;
  logic [CHAN_BITS-1:0] gnt_chan;
  logic                 found;
  dma_req_t             gnt_req;
  logic [LEN_BITS-1:0]  len_m1;
  mux_seq_t             route_entry;

  // Queue status
  logic                 route_rdy;
  logic                 cpl_rdy;
  logic                 cpl_valid;
  logic [CHAN_BITS-1:0] cpl_chan;

  // ----------------------------------------
  // Channel links
  // ----------------------------------------
  for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
    assign valid_snk[i]   = req_snk[i].valid;
    assign request_snk[i] = req_snk[i].req;
    // Only the granted channel sees ready
    assign req_snk[i].ready    = grant && (gnt_chan == CHAN_BITS'(i));
    // Done goes to the owner at the completion head
    assign req_snk[i].rsp.done = done_src && (cpl_chan == CHAN_BITS'(i));
  end

  assign ready_src = req_src.ready;
  assign done_src  = req_src.rsp.done;

  // ----------------------------------------
  // Round robin
  // ----------------------------------------
  // First valid channel upward from the pointer, with wrap
  always_comb begin
    found    = 1'b0;
    gnt_chan = rr_ptr;
    for (int i = 0; i < N_CHAN; i++) begin
      if (!found && valid_snk[(int'(rr_ptr) + i) % N_CHAN]) begin
        found    = 1'b1;
        gnt_chan = CHAN_BITS'((int'(rr_ptr) + i) % N_CHAN);
      end
    end
  end

  // Pointer steps once per grant, whoever won
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rr_ptr <= '0;
    end else if (grant) begin
      rr_ptr <= (rr_ptr == N_CHAN - 1) ? '0 : rr_ptr + 1'b1;
    end
  end

  // Both queues need room before a command goes out
  assign valid_src = found && route_rdy && cpl_rdy;
  assign grant     = valid_src && ready_src;
  assign gnt_req   = request_snk[gnt_chan];

  assign req_src.valid = valid_src;
  assign req_src.req   = gnt_req;

  // Beats minus one
  assign len_m1      = gnt_req.len - 1'b1;
  assign route_entry = '{last: gnt_req.ctl, chan: gnt_chan,
                         n_tr: len_m1[LEN_BITS-1:BEAT_LOG_BITS]};

  // ----------------------------------------
  // Sequence queues
  // ----------------------------------------
  seq_queue #(.QTYPE(mux_seq_t)) i_route_q (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .val_snk  (grant),
    .rdy_snk  (route_rdy),
    .data_snk (route_entry),
    .val_src  (mux.valid),
    .rdy_src  (mux.ready),
    .data_src (mux.data)
  );

  // Popped by each done from the data mux
  seq_queue #(.QTYPE(logic [CHAN_BITS-1:0])) i_cpl_q (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .val_snk  (grant),
    .rdy_snk  (cpl_rdy),
    .data_snk (gnt_chan),
    .val_src  (cpl_valid),
    .rdy_src  (done_src),
    .data_src (cpl_chan)
  );

  // Mux never finishes a request the arbiter did not grant
  a_done_has_owner: assert property (@(posedge aclk) disable iff (!aresetn)
    done_src |-> cpl_valid);

endmodule

// File: logic/dma_data_mux.sv
/* Splits the read data stream across the channels, one request at a time.
   Head of the routing queue picks the channel and the beat count */
`timescale 1ns/1ps

module dma_data_mux
  import dma_pkg::*;
(
  input  logic                 aclk,
  input  logic                 aresetn,
  meta_if.s                    seq,
  input  logic                 rd_valid,
  output logic                 rd_ready,
  input  logic [DATA_BITS-1:0] rd_data,
  output logic [N_CHAN-1:0]    out_valid,
  input  logic [N_CHAN-1:0]    out_ready,
  output logic [DATA_BITS-1:0] out_data [N_CHAN],
  output logic [N_CHAN-1:0]    out_last,
  output logic                 done
);

  mux_seq_t             head;
  logic [BLEN_BITS-1:0] beat_cnt;
  logic                 beat;
  logic                 final_beat;

  assign head = seq.data;

  // ----------------------------------------
  // Beat path
  // ----------------------------------------
  // Stall when no route or the owner is busy
  assign rd_ready   = seq.valid && out_ready[head.chan];
  assign beat       = rd_valid && rd_ready;
  assign final_beat = (beat_cnt == head.n_tr);

  // Request completes on its last accepted beat
  assign done      = beat && final_beat;
  assign seq.ready = done;

  for (genvar i = 0; i < N_CHAN; i++) begin : g_out
    assign out_valid[i] = seq.valid && rd_valid && (head.chan == CHAN_BITS'(i));
    // Payload is shared, valid picks the owner
    assign out_data[i]  = rd_data;
    // tlast only when the transfer ends here
    assign out_last[i]  = seq.valid && (head.chan == CHAN_BITS'(i)) &&
                          head.last && final_beat;
  end

  // ----------------------------------------
  // Beat counter
  // ----------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      beat_cnt <= '0;
    end else if (beat) begin
      if (final_beat) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // Counter stays within the head request's beats
  a_cnt_in_range: assert property (@(posedge aclk) disable iff (!aresetn)
    seq.valid |-> (beat_cnt <= head.n_tr));

endmodule

// File: logic/dma_rd_top.sv
/* Read DMA front end top level with plain ports.
   Wraps the ports into links and connects arbiter and data mux */
`timescale 1ns/1ps

module dma_rd_top
  import dma_pkg::*;
(
  input  logic                 aclk,
  input  logic                 aresetn,
  // User channels
  input  logic [N_CHAN-1:0]    req_valid,
  output logic [N_CHAN-1:0]    req_ready,
  input  logic [ADDR_BITS-1:0] req_addr [N_CHAN],
  input  logic [LEN_BITS-1:0]  req_len [N_CHAN],
  input  logic [N_CHAN-1:0]    req_ctl,
  output logic [N_CHAN-1:0]    req_done,
  // Command port
  output logic                 cmd_valid,
  input  logic                 cmd_ready,
  output logic [ADDR_BITS-1:0] cmd_addr,
  output logic [LEN_BITS-1:0]  cmd_len,
  // Read data in
  input  logic                 rd_valid,
  output logic                 rd_ready,
  input  logic [DATA_BITS-1:0] rd_data,
  // Per-channel data out
  output logic [N_CHAN-1:0]    out_valid,
  input  logic [N_CHAN-1:0]    out_ready,
  output logic [DATA_BITS-1:0] out_data [N_CHAN],
  output logic [N_CHAN-1:0]    out_last
);

  dma_req_if                   chan_if [N_CHAN] ();
  dma_req_if                   cmd_if ();
  meta_if #(.STYPE(mux_seq_t)) seq_if ();
  logic                        seq_done;

  // Channel ports into links
  for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
    assign chan_if[i].valid = req_valid[i];
    assign chan_if[i].req   = '{addr: req_addr[i], len: req_len[i], ctl: req_ctl[i]};
    assign req_ready[i]     = chan_if[i].ready;
    assign req_done[i]      = chan_if[i].rsp.done;
  end

  // Command link out to ports, done fed back from the mux
  assign cmd_valid       = cmd_if.valid;
  assign cmd_addr        = cmd_if.req.addr;
  assign cmd_len         = cmd_if.req.len;
  assign cmd_if.ready    = cmd_ready;
  assign cmd_if.rsp.done = seq_done;

  dma_arbiter i_arbiter (
    .aclk    (aclk),
    .aresetn (aresetn),
    .req_snk (chan_if),
    .req_src (cmd_if),
    .mux     (seq_if)
  );

  dma_data_mux i_data_mux (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .seq       (seq_if),
    .rd_valid  (rd_valid),
    .rd_ready  (rd_ready),
    .rd_data   (rd_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_last  (out_last),
    .done      (seq_done)
  );

endmodule

// File: dv/dma_rd_model.sv
/* Reference model of the read DMA front end for the testbench.
   Predicts round-robin grants and keeps the commands whose beats are due */
`timescale 1ns/1ps

module dma_rd_model
  import dma_pkg::*;
();

  // One accepted command
  typedef struct packed {
    int unsigned chan;
    int unsigned beats;
    bit          last;
  } cmd_t;

  int unsigned rr_ptr   = 0;
  int unsigned beat_idx = 0;
  cmd_t        cmd_q [$];

  // ----------------------------------------
  // Grant prediction
  // ----------------------------------------
  // First valid channel upward from the pointer, N_CHAN when none
  function automatic int unsigned predict_grant(input logic [N_CHAN-1:0] valid);
    for (int i = 0; i < N_CHAN; i++) begin
      if (valid[(rr_ptr + i) % N_CHAN]) begin
        return (rr_ptr + i) % N_CHAN;
      end
    end
    return N_CHAN;
  endfunction

  // Pointer moves after every accepted command
  function automatic void push_cmd(input int unsigned chan, input int unsigned len,
                                   input bit ctl);
    cmd_t c;
    c.chan  = chan;
    // 8 bytes per beat, rounded up
    c.beats = ((len - 1) >> 3) + 1;
    c.last  = ctl;
    cmd_q.push_back(c);
    rr_ptr = (rr_ptr + 1) % N_CHAN;
  endfunction

  // ----------------------------------------
  // Beat tracking
  // ----------------------------------------
  function automatic int unsigned outstanding();
    return cmd_q.size();
  endfunction

  function automatic int unsigned head_chan();
    return cmd_q[0].chan;
  endfunction

  function automatic bit head_final();
    return beat_idx == cmd_q[0].beats - 1;
  endfunction

  function automatic bit head_last();
    return cmd_q[0].last;
  endfunction

  // Final beat retires the command
  function automatic void retire_beat();
    if (head_final()) begin
      void'(cmd_q.pop_front());
      beat_idx = 0;
    end else begin
      beat_idx++;
    end
  endfunction

endmodule

// File: dv/dma_rd_tb.sv
/* Testbench for the read DMA front end with random channel traffic.
   Checks grants, commands, beat routing, tlast and done against dma_rd_model */
`timescale 1ns/1ps

module dma_rd_tb;
  import dma_pkg::*;

  localparam int unsigned WAIT_LIMIT = 20000;

  logic                 aclk;
  logic                 aresetn;
  logic [N_CHAN-1:0]    req_valid;
  logic [N_CHAN-1:0]    req_ready;
  logic [ADDR_BITS-1:0] req_addr [N_CHAN];
  logic [LEN_BITS-1:0]  req_len [N_CHAN];
  logic [N_CHAN-1:0]    req_ctl;
  logic [N_CHAN-1:0]    req_done;
  logic                 cmd_valid;
  logic                 cmd_ready;
  logic [ADDR_BITS-1:0] cmd_addr;
  logic [LEN_BITS-1:0]  cmd_len;
  logic                 rd_valid;
  logic                 rd_ready;
  logic [DATA_BITS-1:0] rd_data;
  logic [N_CHAN-1:0]    out_valid;
  logic [N_CHAN-1:0]    out_ready;
  logic [DATA_BITS-1:0] out_data [N_CHAN];
  logic [N_CHAN-1:0]    out_last;

  // Stimulus knobs and handshakes seen by the monitor
  bit                gen_on;
  bit                rd_on;
  logic [N_CHAN-1:0] req_taken;
  bit                rd_taken;
  int unsigned       n_cmds;

  dma_rd_top i_dut (.*);

  dma_rd_model i_model ();

  always #20 aclk = ~aclk;

  task automatic check_value(input string what, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("Test failures found");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    $display("Test failures found");
    $fatal(1, "Timeout");
  endtask

  // ----------------------------------------
  // Driver, 2 ns after the rising edge
  // ----------------------------------------
  always @(posedge aclk) begin
    #2;
    for (int i = 0; i < N_CHAN; i++) begin
      // Request holds until its handshake
      if (!req_valid[i] || req_taken[i]) begin
        req_valid[i] = gen_on && ($urandom % 4 == 0);
        req_addr[i]  = $urandom;
        req_len[i]   = LEN_BITS'(1 + $urandom % 64);
        req_ctl[i]   = 1'($urandom);
      end
      out_ready[i] = ($urandom % 4) != 0;
    end
    cmd_ready = ($urandom % 4) != 0;
    if (!rd_valid || rd_taken) begin
      rd_valid = rd_on && ($urandom % 3 != 0);
      rd_data  = {$urandom, $urandom};
    end
  end

  // ----------------------------------------
  // Monitor and checks on the falling edge
  // ----------------------------------------
  always @(negedge aclk) begin : monitor
    int unsigned n_out;
    int unsigned hc;
    int unsigned g;
    bit          fin;
    if (aresetn) begin
      n_out = i_model.outstanding();
      if (n_out > 0) begin
        hc  = i_model.head_chan();
        fin = i_model.head_final();
        check_value("rd_ready", rd_ready, out_ready[hc]);
        check_value("out_valid", out_valid, rd_valid ? (64'd1 << hc) : 64'd0);
        if (rd_valid && rd_ready) begin
          check_value("out_data", out_data[hc], rd_data);
          check_value("out_last", out_last,
                      (fin && i_model.head_last()) ? (64'd1 << hc) : 64'd0);
          // Done on the owner, in the cycle of the final beat
          check_value("req_done", req_done, fin ? (64'd1 << hc) : 64'd0);
          i_model.retire_beat();
        end else begin
          check_value("req_done", req_done, 0);
        end
      end else begin
        check_value("rd_ready", rd_ready, 0);
        check_value("out_valid", out_valid, 0);
        check_value("req_done", req_done, 0);
      end
      // Command side, blocked while the queues are full
      g = i_model.predict_grant(req_valid);
      check_value("cmd_valid", cmd_valid, (g < N_CHAN) && (n_out < N_OUTSTANDING));
      if (cmd_valid && cmd_ready) begin
        check_value("req_ready", req_ready, 64'd1 << g);
        check_value("cmd_addr", cmd_addr, req_addr[g]);
        check_value("cmd_len", cmd_len, req_len[g]);
        i_model.push_cmd(g, req_len[g], req_ctl[g]);
        n_cmds++;
      end else begin
        check_value("req_ready", req_ready, 0);
      end
      req_taken = req_valid & req_ready;
      rd_taken  = rd_valid && rd_ready;
    end else begin
      req_taken = '0;
      rd_taken  = 1'b0;
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : sequence_main
    int unsigned cyc;
    void'($urandom(32'hf54e_946a));
    aclk      = 1'b0;
    aresetn   = 1'b0;
    req_valid = '0;
    req_ctl   = '0;
    for (int i = 0; i < N_CHAN; i++) begin
      req_addr[i] = '0;
      req_len[i]  = '0;
    end
    cmd_ready = 1'b0;
    rd_valid  = 1'b0;
    rd_data   = '0;
    out_ready = '0;
    gen_on    = 1'b0;
    rd_on     = 1'b0;
    req_taken = '0;
    rd_taken  = 1'b0;
    n_cmds    = 0;
    repeat (8) @(posedge aclk);
    #2 aresetn = 1'b1;

    // Mixed traffic
    gen_on = 1'b1;
    rd_on  = 1'b1;
    cyc    = 0;
    while (n_cmds < 300) begin
      @(posedge aclk);
      cyc++;
      if (cyc > WAIT_LIMIT) begin
        report_timeout("300 commands");
      end
    end

    // No read data, the queues must fill up and block
    rd_on = 1'b0;
    cyc   = 0;
    while (i_model.outstanding() < N_OUTSTANDING) begin
      @(posedge aclk);
      cyc++;
      if (cyc > WAIT_LIMIT) begin
        report_timeout("a full set of outstanding requests");
      end
    end
    repeat (50) @(posedge aclk);
    check_value("outstanding", i_model.outstanding(), N_OUTSTANDING);

    // Drain everything
    rd_on  = 1'b1;
    gen_on = 1'b0;
    cyc    = 0;
    while ((req_valid != '0) || (i_model.outstanding() != 0)) begin
      @(posedge aclk);
      cyc++;
      if (cyc > WAIT_LIMIT) begin
        report_timeout("the drain of all requests");
      end
    end
    repeat (4) @(posedge aclk);
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: dma_rd_top.f
logic/dma_pkg.sv
logic/dma_req_if.sv
logic/meta_if.sv
logic/seq_queue.sv
logic/dma_arbiter.sv
logic/dma_data_mux.sv
logic/dma_rd_top.sv
dv/dma_rd_model.sv
dv/dma_rd_tb.sv

// File: Bender.yml
package:
  name: dma_rd

sources:
  # Package first, then interfaces, then RTL bottom up
  - files:
      - logic/dma_pkg.sv
      - logic/dma_req_if.sv
      - logic/meta_if.sv
      - logic/seq_queue.sv
      - logic/dma_arbiter.sv
      - logic/dma_data_mux.sv
      - logic/dma_rd_top.sv
  - target: test
    files:
      - dv/dma_rd_model.sv
      - dv/dma_rd_tb.sv
